//--- verification/filter_tests.txt
# flags mask self_mac self_bssid type subtype tofrom_ds length addr1 addr2 addr3 exp_block
# all columns hex, one frame per line
0200 000 112233445566 aabbccddeeff 2 0 0 001a 112233445566 0708090a0b0c aabbccddeeff 0
0000 000 112233445566 aabbccddeeff 2 0 0 001a 112233445566 0708090a0b0c aabbccddeeff 1
0400 000 112233445566 aabbccddeeff 2 0 0 001a ffffffffffff 0708090a0b0c aabbccddeeff 0
0800 000 112233445566 aabbccddeeff 2 0 0 001a ffffffffffff 0708090a0b0c aabbccddeeff 1
0800 000 112233445566 aabbccddeeff 2 0 0 001a 000000000000 0708090a0b0c aabbccddeeff 0
0400 000 112233445566 aabbccddeeff 2 0 0 001a 000000000000 0708090a0b0c aabbccddeeff 1
0000 002 112233445566 aabbccddeeff 2 0 0 001a 0a0b0c5e0001 0708090a0b0c aabbccddeeff 1
0002 002 112233445566 aabbccddeeff 2 0 0 001a 0a0b0c5e0001 0708090a0b0c aabbccddeeff 0
0040 000 112233445566 aabbccddeeff 2 0 0 001a 0c0d0e0f3333 0708090a0b0c a0a1a2a3a4a5 0
0040 002 112233445566 aabbccddeeff 2 0 0 001a 0c0d0e0f3333 0708090a0b0c a0a1a2a3a4a5 1
0010 010 112233445566 aabbccddeeff 0 8 0 001a ffffffffffff a0a1a2a3a4a5 a0a1a2a3a4a5 0
0400 010 112233445566 aabbccddeeff 0 8 0 001a ffffffffffff a0a1a2a3a4a5 a0a1a2a3a4a5 1
0400 000 112233445566 aabbccddeeff 0 8 0 001a ffffffffffff a0a1a2a3a4a5 a0a1a2a3a4a5 0
0020 020 112233445566 aabbccddeeff 1 b 0 0014 112233445566 0708090a0b0c 000000000000 0
0200 020 112233445566 aabbccddeeff 1 b 0 0014 112233445566 0708090a0b0c 000000000000 1
0200 000 112233445566 aabbccddeeff 1 b 0 0014 112233445566 0708090a0b0c 000000000000 0
0080 080 112233445566 aabbccddeeff 1 a 0 0014 112233445566 0708090a0b0c 000000000000 0
0200 080 112233445566 aabbccddeeff 1 a 0 0014 112233445566 0708090a0b0c 000000000000 1
0100 100 112233445566 aabbccddeeff 0 4 0 001a ffffffffffff 0708090a0b0c ffffffffffff 0
0400 100 112233445566 aabbccddeeff 0 4 0 001a ffffffffffff 0708090a0b0c ffffffffffff 1
0400 000 112233445566 aabbccddeeff 0 4 0 001a ffffffffffff 0708090a0b0c ffffffffffff 0
0200 040 112233445566 aabbccddeeff 2 0 0 001a 112233445566 0708090a0b0c a0a1a2a3a4a5 1
0240 040 112233445566 aabbccddeeff 2 0 0 001a 112233445566 0708090a0b0c a0a1a2a3a4a5 0
0040 040 112233445566 aabbccddeeff 2 0 2 001a a0a1a2a3a4a5 0708090a0b0c aabbccddeeff 0
0040 040 112233445566 aabbccddeeff 2 0 1 001a 0708090a0b0c a0a1a2a3a4a5 aabbccddeeff 0
0040 040 112233445566 aabbccddeeff 2 0 1 001a 0708090a0b0c aabbccddeeff a0a1a2a3a4a5 1
0040 040 112233445566 aabbccddeeff 2 0 3 001a 0708090a0b0c a0a1a2a3a4a5 a0a1a2a3a4a5 1
1000 1ff 112233445566 aabbccddeeff 0 8 0 001a ffffffffffff 0708090a0b0c aabbccddeeff 0
1040 1ff 112233445566 aabbccddeeff 0 8 0 001a ffffffffffff 0708090a0b0c a0a1a2a3a4a5 1
0200 000 112233445566 aabbccddeeff 2 0 0 000a 112233445566 0708090a0b0c aabbccddeeff 1
0200 000 112233445566 aabbccddeeff 2 0 0 0011 112233445566 0708090a0b0c aabbccddeeff 1
0200 000 112233445566 aabbccddeeff 2 0 0 0017 112233445566 0708090a0b0c aabbccddeeff 1
2000 000 112233445566 aabbccddeeff 2 0 0 000a 112233445566 0708090a0b0c aabbccddeeff 0
2200 000 112233445566 aabbccddeeff 2 0 0 0011 112233445566 0708090a0b0c aabbccddeeff 0
2000 1ff 112233445566 aabbccddeeff 2 0 0 0017 112233445566 0708090a0b0c aabbccddeeff 0
0200 000 112233445566 aabbccddeeff 2 0 0 000e 112233445566 0708090a0b0c aabbccddeeff 0
0200 000 112233445566 aabbccddeeff 2 0 0 001e 112233445566 0708090a0b0c aabbccddeeff 0
2000 1ff 112233445566 aabbccddeeff 2 0 0 001a 0a0b0c5e0001 0708090a0b0c a0a1a2a3a4a5 0

//--- flist.f
hdl/pkt_filter_pkg.sv
hdl/hdr_tracker.sv
hdl/filter_rules.sv
hdl/verdict_port.sv
hdl/pkt_filter_top.sv
verification/pkt_filter_props.sv
verification/pkt_filter_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the frame filter testbench with Verilator
set -e

rm -rf obj_dir
verilator --binary --timing --assert --top-module pkt_filter_tb -f flist.f -o pkt_filter_sim

./obj_dir/pkt_filter_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    exit 1
fi
exit 0

//--- verification/pkt_filter_tb.sv
// Rx frame filter testbench

`timescale 1ns/1ps

module pkt_filter_tb;
    import pkt_filter_pkg::*;

    localparam int MAX_TESTS = 64;

    logic             clk;
    logic             rstn;
    filter_cfg_t      cfg;
    logic             ht_unsupport;
    fc_t              fc;
    logic [15:0]      signal_len;
    logic             sig_valid;
    logic [MAC_W-1:0] addr1;
    logic             addr1_valid;
    logic [MAC_W-1:0] addr2;
    logic             addr2_valid;
    logic [MAC_W-1:0] addr3;
    logic             addr3_valid;
    logic             ack;
    logic             req;
    logic             block;

    // one entry per frame in the tests file
    logic [13:0]      t_flags [MAX_TESTS];
    logic [8:0]       t_mask  [MAX_TESTS];
    logic [MAC_W-1:0] t_self  [MAX_TESTS];
    logic [MAC_W-1:0] t_bss   [MAX_TESTS];
    logic [1:0]       t_type  [MAX_TESTS];
    logic [3:0]       t_sub   [MAX_TESTS];
    logic [1:0]       t_ds    [MAX_TESTS];
    logic [15:0]      t_len   [MAX_TESTS];
    logic [MAC_W-1:0] t_a1    [MAX_TESTS];
    logic [MAC_W-1:0] t_a2    [MAX_TESTS];
    logic [MAC_W-1:0] t_a3    [MAX_TESTS];
    logic             t_exp   [MAX_TESTS];

    int          n_tests;
    int          verdicts;
    logic        req_q;
    logic        loaded;
    logic [31:0] rng_state;

    pkt_filter_top dut (
        .clk          (clk),
        .rstn         (rstn),
        .cfg          (cfg),
        .ht_unsupport (ht_unsupport),
        .fc           (fc),
        .signal_len   (signal_len),
        .sig_valid    (sig_valid),
        .addr1        (addr1),
        .addr1_valid  (addr1_valid),
        .addr2        (addr2),
        .addr2_valid  (addr2_valid),
        .addr3        (addr3),
        .addr3_valid  (addr3_valid),
        .ack          (ack),
        .req          (req),
        .block        (block)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one rising edge of req per verdict
    always @(posedge clk)
    begin
        if (!rstn)
        begin
            req_q    <= 1'b0;
            verdicts <= 0;
        end
        else
        begin
            req_q <= req;
            if (req && !req_q)
                verdicts <= verdicts + 1;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        begin
            y = x ^ (x << 13);
            y = y ^ (y >> 17);
            y = y ^ (y << 5);
            return y;
        end
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        begin
            if (got !== exp)
            begin
                $display("error at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
                $display("Verification failed");
                $fatal(1);
            end
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          cnt;
        string       line;
        logic [13:0] flags;
        logic [8:0]  mask;
        logic [47:0] self_mac;
        logic [47:0] self_bss;
        logic [1:0]  ftype;
        logic [3:0]  sub;
        logic [1:0]  ds;
        logic [15:0] len;
        logic [47:0] a1;
        logic [47:0] a2;
        logic [47:0] a3;
        logic        exp;
        begin
            n_tests = 0;
            fd = $fopen("verification/filter_tests.txt", "r");
            if (fd == 0)
            begin
                $display("could not open the tests file");
                $display("Verification failed");
                $fatal(1);
            end
            while (!$feof(fd) && n_tests < MAX_TESTS)
            begin
                line = "";
                cnt = $fgets(line, fd);
                if (line.len() > 1 && line[0] != 8'h23)  // skip comment lines
                begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", flags, mask,
                                  self_mac, self_bss, ftype, sub, ds, len, a1, a2, a3, exp);
                    if (cnt == 12)
                    begin
                        t_flags[n_tests] = flags;
                        t_mask[n_tests]  = mask;
                        t_self[n_tests]  = self_mac;
                        t_bss[n_tests]   = self_bss;
                        t_type[n_tests]  = ftype;
                        t_sub[n_tests]   = sub;
                        t_ds[n_tests]    = ds;
                        t_len[n_tests]   = len;
                        t_a1[n_tests]    = a1;
                        t_a2[n_tests]    = a2;
                        t_a3[n_tests]    = a3;
                        t_exp[n_tests]   = exp;
                        n_tests = n_tests + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_cycles(input int n);
        begin
            repeat (n)
            begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // drive one frame and complete its handshake
    task automatic run_frame(input int i);
        int  n_addr;
        int  gap;
        int  cycles;
        int  ack_delay;
        bit  short_hdr;
        begin
            if (t_len[i] < 16'd14)
                n_addr = 0;
            else if (t_len[i] < 16'd20)
                n_addr = 1;
            else if (t_len[i] < 16'd26)
                n_addr = 2;
            else
                n_addr = 3;
            short_hdr = (t_len[i] != 16'd14) && (t_len[i] != 16'd20) && (t_len[i] < 16'd26);

            cfg        = '{flags: t_flags[i], discard_mask: t_mask[i],
                           self_mac: t_self[i], self_bssid: t_bss[i]};
            fc         = '{ftype: t_type[i], subtype: t_sub[i], tofrom_ds: t_ds[i]};
            signal_len = t_len[i];
            addr1      = t_a1[i];
            addr2      = t_a2[i];
            addr3      = t_a3[i];
            sig_valid  = 1'b1;
            @(posedge clk);
            #1;
            sig_valid = 1'b0;

            for (int k = 1; k <= n_addr; k++)
            begin
                rng_state = next_random(rng_state);
                gap = {30'd0, rng_state[1:0]};
                wait_cycles(gap);
                addr1_valid = (k == 1);
                addr2_valid = (k == 2);
                addr3_valid = (k == 3);
                @(posedge clk);
                #1;
                addr1_valid = 1'b0;
                addr2_valid = 1'b0;
                addr3_valid = 1'b0;
            end

            cycles = 1;
            while (!req)
            begin
                @(posedge clk);
                #1;
                cycles = cycles + 1;
            end
            if (!short_hdr)
                check_value($sformatf("frame %0d req latency", i), 64'(cycles), 64'd3);
            else if (n_addr == 0)
                check_value($sformatf("frame %0d abnormal req latency", i),
                            64'(cycles), 64'd4);

            rng_state = next_random(rng_state);
            if (i % 6 == 5)
                ack_delay = 25;  // long back-pressure
            else
                ack_delay = {29'd0, rng_state[2:0]};
            wait_cycles(ack_delay);
            check_value($sformatf("frame %0d block", i), {63'd0, block}, {63'd0, t_exp[i]});

            ack = 1'b1;
            while (req)
            begin
                @(posedge clk);
                #1;
            end
            ack = 1'b0;
            wait_cycles(2);
        end
    endtask

    initial
    begin
        loaded       = 1'b0;
        rstn         = 1'b0;
        cfg          = '0;
        ht_unsupport = 1'b0;
        fc           = '0;
        signal_len   = '0;
        sig_valid    = 1'b0;
        addr1        = '0;
        addr1_valid  = 1'b0;
        addr2        = '0;
        addr2_valid  = 1'b0;
        addr3        = '0;
        addr3_valid  = 1'b0;
        ack          = 1'b0;
        rng_state    = 32'd47858;

        load_tests();
        if (n_tests == 0)
        begin
            $display("the tests file holds no frames");
            $display("Verification failed");
            $fatal(1);
        end
        loaded = 1'b1;

        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        wait_cycles(2);

        for (int i = 0; i < n_tests; i++)
            run_frame(i);

        check_value("verdict count", 64'(verdicts), 64'(n_tests));
        $display("Verification passed");
        $finish;
    end

    initial
    begin
        wait (loaded);
        #((n_tests * 60 + 10) * 10);
        $display("watchdog expired before all frames were checked");
        $display("Verification failed");
        $fatal(1);
    end

endmodule

//--- verification/pkt_filter_props.sv
// Frame filter assertions

`timescale 1ns/1ps

module pkt_filter_props (
    input logic clk,
    input logic rstn,
    input logic req,
    input logic ack,
    input logic block,
    input logic eval,
    input logic verdict_valid
);

    logic eval_pending;  // eval seen, verdict not yet out

    always_ff @(posedge clk)
    begin
        if (!rstn)
            eval_pending <= 1'b0;
        else if (eval)
            eval_pending <= 1'b1;
        else if (verdict_valid)
            eval_pending <= 1'b0;
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        (req && !ack) |=> req)
        else $error("req fell before ack rose");

    a_block_stable: assert property (@(posedge clk) disable iff (!rstn)
        req |=> (!req || $stable(block)))
        else $error("block changed while req high");

    a_eval_once: assert property (@(posedge clk) disable iff (!rstn)
        eval |-> !eval_pending)
        else $error("second eval without a verdict");

endmodule

bind pkt_filter_top pkt_filter_props u_props (
    .clk           (clk),
    .rstn          (rstn),
    .req           (req),
    .ack           (ack),
    .block         (block),
    .eval          (eval),
    .verdict_valid (verdict_valid)
);

//--- hdl/pkt_filter_top.sv
// Rx frame filter top

`timescale 1ns/1ps

module pkt_filter_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  pkt_filter_pkg::filter_cfg_t       cfg,
    input  logic                              ht_unsupport,
    input  pkt_filter_pkg::fc_t               fc,
    input  logic [15:0]                       signal_len,
    input  logic                              sig_valid,
    input  logic [pkt_filter_pkg::MAC_W-1:0]  addr1,
    input  logic                              addr1_valid,
    input  logic [pkt_filter_pkg::MAC_W-1:0]  addr2,
    input  logic                              addr2_valid,
    input  logic [pkt_filter_pkg::MAC_W-1:0]  addr3,
    input  logic                              addr3_valid,
    input  logic                              ack,
    output logic                              req,
    output logic                              block
);
    import pkt_filter_pkg::*;

    hdr_summary_t summary;
    logic         eval;
    logic         verdict_valid;
    logic         block_raw;
    logic         busy;

    hdr_tracker u_tracker (
        .clk          (clk),
        .rstn         (rstn),
        .busy         (busy),
        .ht_unsupport (ht_unsupport),
        .fc           (fc),
        .signal_len   (signal_len),
        .sig_valid    (sig_valid),
        .addr1        (addr1),
        .addr1_valid  (addr1_valid),
        .addr2        (addr2),
        .addr2_valid  (addr2_valid),
        .addr3        (addr3),
        .addr3_valid  (addr3_valid),
        .summary      (summary),
        .eval         (eval)
    );

    filter_rules u_rules (
        .clk           (clk),
        .rstn          (rstn),
        .eval          (eval),
        .summary       (summary),
        .cfg           (cfg),
        .verdict_valid (verdict_valid),
        .block         (block_raw)
    );

    verdict_port u_port (
        .clk           (clk),
        .rstn          (rstn),
        .verdict_valid (verdict_valid),
        .block_in      (block_raw),
        .ack           (ack),
        .req           (req),
        .block         (block),
        .busy          (busy)     // holds off the next frame
    );

endmodule

//--- hdl/verdict_port.sv
// Verdict req/ack port

`timescale 1ns/1ps

module verdict_port (
    input  logic clk,
    input  logic rstn,
    input  logic verdict_valid,
    input  logic block_in,
    input  logic ack,
    output logic req,
    output logic block,
    output logic busy
);

    logic wait_low;  // req dropped, ack still high

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            req      <= 1'b0;
            wait_low <= 1'b0;
        end
        else if (req)
        begin
            if (ack)
            begin
                req      <= 1'b0;
                wait_low <= 1'b1;
            end
        end
        else if (wait_low)
        begin
            if (!ack)
                wait_low <= 1'b0;
        end
        else if (verdict_valid)
            req <= 1'b1;
    end

    // held stable for the whole handshake
    always_ff @(posedge clk)
    begin
        if (verdict_valid && !req && !wait_low)
            block <= block_in;
    end

    assign busy = verdict_valid || req || wait_low;

endmodule

//--- hdl/filter_rules.sv
// Frame filter rule evaluation

`timescale 1ns/1ps

module filter_rules (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          eval,
    input  pkt_filter_pkg::hdr_summary_t  summary,
    input  pkt_filter_pkg::filter_cfg_t   cfg,
    output logic                          verdict_valid,
    output logic                          block
);
    import pkt_filter_pkg::*;

    logic [CFG_W-1:0]  f;
    logic [CFG_W-1:0]  allow;
    logic [DISC_W-1:0] discard;
    logic              is_mcast;
    logic              is_beacon;
    logic              is_bcn_presp;
    logic              is_probe_req;
    logic              is_ctrl;
    logic              is_pspoll;
    logic              to_self;
    logic              foreign_bss;
    logic              own_bss;
    logic              block_nxt;

    assign f = cfg.flags;

    // frame classes
    assign is_mcast     = (summary.addr1[23:0] == MCAST_V4_PREFIX) ||
                          (summary.addr1[15:0] == MCAST_V6_PREFIX);
    assign is_beacon    = (summary.fc.ftype == FC_TYPE_MGMT) &&
                          (summary.fc.subtype == SUB_BEACON);
    assign is_bcn_presp = is_beacon || ((summary.fc.ftype == FC_TYPE_MGMT) &&
                          (summary.fc.subtype == SUB_PROBE_RESP));
    assign is_probe_req = (summary.fc.ftype == FC_TYPE_MGMT) &&
                          (summary.fc.subtype == SUB_PROBE_REQ);
    assign is_pspoll    = (summary.fc.ftype == FC_TYPE_CTRL) &&
                          (summary.fc.subtype == SUB_PSPOLL);
    assign is_ctrl      = (summary.fc.ftype == FC_TYPE_CTRL) && !is_pspoll; // ps-poll has its own flag
    assign to_self      = (summary.addr1 == cfg.self_mac);
    assign foreign_bss  = summary.bssid_valid && (summary.bssid != cfg.self_bssid);
    assign own_bss      = summary.bssid_valid && (summary.bssid == cfg.self_bssid);

    always_comb
    begin
        allow   = '0;
        discard = '0;
        if (summary.abnormal)
            discard = '1;
        else
        begin
            allow[FIF_ALLMULTI]            = f[FIF_ALLMULTI] && is_mcast;
            allow[FIF_BCN_PRBRESP_PROMISC] = f[FIF_BCN_PRBRESP_PROMISC] && is_bcn_presp;
            allow[FIF_CONTROL]             = f[FIF_CONTROL] && is_ctrl && to_self;
            allow[FIF_OTHER_BSS]           = f[FIF_OTHER_BSS] && foreign_bss;
            allow[FIF_PSPOLL]              = f[FIF_PSPOLL] && is_pspoll;
            allow[FIF_PROBE_REQ]           = f[FIF_PROBE_REQ] && is_probe_req;
            allow[UNICAST_FOR_US]          = f[UNICAST_FOR_US] && to_self;
            allow[BROADCAST_ALL_ONE]       = f[BROADCAST_ALL_ONE] &&
                                             (summary.addr1 == BCAST_ALL_ONE);
            allow[BROADCAST_ALL_ZERO]      = f[BROADCAST_ALL_ZERO] &&
                                             (summary.addr1 == BCAST_ALL_ZERO);
            allow[MY_BEACON]               = f[MY_BEACON] && is_beacon && own_bss;
            allow[MONITOR_ALL]             = f[MONITOR_ALL];

            // same classes with the flag cleared
            discard[FIF_ALLMULTI]            = !f[FIF_ALLMULTI] && is_mcast;
            discard[FIF_BCN_PRBRESP_PROMISC] = !f[FIF_BCN_PRBRESP_PROMISC] &&
                                               is_bcn_presp && foreign_bss;
            discard[FIF_CONTROL]             = !f[FIF_CONTROL] && is_ctrl;
            discard[FIF_OTHER_BSS]           = !f[FIF_OTHER_BSS] && foreign_bss;
            discard[FIF_PSPOLL]              = !f[FIF_PSPOLL] && is_pspoll;
            discard[FIF_PROBE_REQ]           = !f[FIF_PROBE_REQ] && is_probe_req;
        end
    end

    // monitor mode overrides every other rule
    assign block_nxt = !f[MONITOR_ALL] &&
                       (!(|allow) || (|(discard & cfg.discard_mask)));

    always_ff @(posedge clk)
    begin
        if (!rstn)
            verdict_valid <= 1'b0;
        else
            verdict_valid <= eval;
    end

    always_ff @(posedge clk)
    begin
        if (eval)
            block <= block_nxt;
    end

endmodule

//--- hdl/hdr_tracker.sv
// Header field tracker

`timescale 1ns/1ps

module hdr_tracker (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                busy,
    input  logic                                ht_unsupport,
    input  pkt_filter_pkg::fc_t                 fc,
    input  logic [15:0]                         signal_len,
    input  logic                                sig_valid,
    input  logic [pkt_filter_pkg::MAC_W-1:0]    addr1,
    input  logic                                addr1_valid,
    input  logic [pkt_filter_pkg::MAC_W-1:0]    addr2,
    input  logic                                addr2_valid,
    input  logic [pkt_filter_pkg::MAC_W-1:0]    addr3,
    input  logic                                addr3_valid,
    output pkt_filter_pkg::hdr_summary_t        summary,
    output logic                                eval
);
    import pkt_filter_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_A1,
        ST_WAIT_A2,
        ST_WAIT_A3,
        ST_EVAL,
        ST_ABNORMAL
    } state_t;

    state_t           state;
    state_t           state_nxt;
    logic [15:0]      len_q;
    fc_t              fc_q;
    logic [MAC_W-1:0] addr1_q;
    logic [MAC_W-1:0] bssid_q;
    logic             bssid_valid_q;
    logic             abnormal_q;
    logic             start;
    logic             take_a1;
    logic             take_a2;
    logic             take_a3;
    logic             bssid_hit;
    logic [MAC_W-1:0] bssid_src;

    assign start   = (state == ST_IDLE) && sig_valid && !busy && !ht_unsupport;
    assign take_a1 = (state == ST_WAIT_A1) && addr1_valid;
    assign take_a2 = (state == ST_WAIT_A2) && addr2_valid;
    assign take_a3 = (state == ST_WAIT_A3) && addr3_valid;

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:     if (start) state_nxt = (signal_len >= MIN_LEN_A1) ? ST_WAIT_A1 : ST_ABNORMAL;
            ST_WAIT_A1:
            begin
                if (take_a1)
                begin
                    if (len_q == MIN_LEN_A1)
                        state_nxt = ST_EVAL;
                    else if (len_q >= MIN_LEN_A2)
                        state_nxt = ST_WAIT_A2;
                    else
                        state_nxt = ST_ABNORMAL; // between 14 and 20
                end
            end
            ST_WAIT_A2:
            begin
                if (take_a2)
                begin
                    if (len_q == MIN_LEN_A2)
                        state_nxt = ST_EVAL;
                    else if (len_q >= MIN_LEN_A3)
                        state_nxt = ST_WAIT_A3;
                    else
                        state_nxt = ST_ABNORMAL; // between 20 and 26
                end
            end
            ST_WAIT_A3:  if (take_a3) state_nxt = ST_EVAL;
            ST_ABNORMAL: state_nxt = ST_EVAL;
            default:     state_nxt = ST_IDLE;  // ST_EVAL lasts one cycle
        endcase
    end

    // bssid source depends on the to/from-DS bits
    always_comb
    begin
        bssid_hit = 1'b0;
        bssid_src = addr3;
        if (take_a1 && fc.tofrom_ds == 2'b10)
        begin
            bssid_hit = 1'b1;
            bssid_src = addr1;
        end
        else if (take_a2 && fc_q.tofrom_ds == 2'b01)
        begin
            bssid_hit = 1'b1;
            bssid_src = addr2;
        end
        else if (take_a3 && fc_q.tofrom_ds == 2'b00)
            bssid_hit = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state         <= ST_IDLE;
            bssid_valid_q <= 1'b0;
            abnormal_q    <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (start)
                bssid_valid_q <= 1'b0;  // never carry a stale bssid over
            else if (bssid_hit)
                bssid_valid_q <= 1'b1;
            if (state_nxt == ST_ABNORMAL)
                abnormal_q <= 1'b1;
            else if (start)
                abnormal_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            len_q <= signal_len;
        if (take_a1)
        begin
            fc_q    <= fc;
            addr1_q <= addr1;
        end
        if (bssid_hit)
            bssid_q <= bssid_src;
    end

    assign summary = '{fc: fc_q, addr1: addr1_q, bssid: bssid_q,
                       bssid_valid: bssid_valid_q, abnormal: abnormal_q};
    assign eval    = (state == ST_EVAL);

endmodule

//--- hdl/pkt_filter_pkg.sv
// Rx frame filter definitions

package pkt_filter_pkg;

    localparam int MAC_W  = 48;
    localparam int CFG_W  = 14;
    localparam int DISC_W = 9;

    // frame length needed to reach each address field
    localparam logic [15:0] MIN_LEN_A1 = 16'd14;
    localparam logic [15:0] MIN_LEN_A2 = 16'd20;
    localparam logic [15:0] MIN_LEN_A3 = 16'd26;

    localparam logic [MAC_W-1:0] BCAST_ALL_ONE  = {MAC_W{1'b1}};
    localparam logic [MAC_W-1:0] BCAST_ALL_ZERO = {MAC_W{1'b0}};

    // first octet sits in the low byte of the address
    localparam logic [23:0] MCAST_V4_PREFIX = 24'h5E0001; // 01:00:5e
    localparam logic [15:0] MCAST_V6_PREFIX = 16'h3333;   // 33:33

    localparam logic [1:0] FC_TYPE_MGMT = 2'd0;
    localparam logic [1:0] FC_TYPE_CTRL = 2'd1;

    localparam logic [3:0] SUB_PROBE_REQ  = 4'd4;
    localparam logic [3:0] SUB_PROBE_RESP = 4'd5;
    localparam logic [3:0] SUB_BEACON     = 4'd8;
    localparam logic [3:0] SUB_PSPOLL     = 4'd10;

    // low filter flag bits follow mac80211
    localparam int FIF_ALLMULTI            = 1;
    localparam int FIF_BCN_PRBRESP_PROMISC = 4;
    localparam int FIF_CONTROL             = 5;
    localparam int FIF_OTHER_BSS           = 6;
    localparam int FIF_PSPOLL              = 7;
    localparam int FIF_PROBE_REQ           = 8;
    localparam int UNICAST_FOR_US          = 9;
    localparam int BROADCAST_ALL_ONE       = 10;
    localparam int BROADCAST_ALL_ZERO      = 11;
    localparam int MY_BEACON               = 12;
    localparam int MONITOR_ALL             = 13;

    typedef struct packed {
        logic [1:0] ftype;
        logic [3:0] subtype;
        logic [1:0] tofrom_ds;
    } fc_t;

    // what the rules need to know about one frame
    typedef struct packed {
        fc_t              fc;
        logic [MAC_W-1:0] addr1;
        logic [MAC_W-1:0] bssid;
        logic             bssid_valid;
        logic             abnormal;   // header shorter than its addresses
    } hdr_summary_t;

    typedef struct packed {
        logic [CFG_W-1:0]  flags;
        logic [DISC_W-1:0] discard_mask;
        logic [MAC_W-1:0]  self_mac;
        logic [MAC_W-1:0]  self_bssid;
    } filter_cfg_t;

endpackage
